/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tbUartLink
FILELIST = all.f
MDIR = obj_dir
SIM = $(MDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

# Output stays on the terminal, grep sets the exit status
run: compile
	./$(SIM) | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null

clean:
	rm -rf $(MDIR)

/* all.f */
+incdir+.
uartPkg.sv
baudTickGen.sv
uartReceiver.sv
byteFifo.sv
uartTransmitter.sv
uartLink.sv
tbUartLink.sv

/* baudTickGen.sv */
`timescale 1ns/1ns
`default_nettype none

module baudTickGen
	import uartPkg::*;
#(
	parameter int ClkFrequency = 50000000,
	parameter int Rate = 115200
) (
	input wire CLK50MHZ,
	input wire rst,
	input wire enable,
	output logic tick
);

	// Increment is Rate/ClkFrequency scaled by 2^BaudAccWidth, rounded to nearest
	localparam longint Scaled = (longint'(Rate) << BaudAccWidth) + longint'(ClkFrequency / 2);
	localparam logic [BaudAccWidth:0] Inc = (BaudAccWidth + 1)'(Scaled / longint'(ClkFrequency));

	logic [BaudAccWidth-1:0] acc;
	logic [BaudAccWidth:0] sum;

	// Carry of the next sum is the tick, so the consumer acts on the same edge
	assign sum = {1'b0, acc} + Inc;
	assign tick = enable && sum[BaudAccWidth];

	// Phase restarts from zero whenever the generator is idle
	always_ff @(posedge CLK50MHZ) begin
		if (rst || !enable) begin
			acc <= '0;
		end else begin
			acc <= sum[BaudAccWidth-1:0];
		end
	end

endmodule

`default_nettype wire

/* byteFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module byteFifo
	import uartPkg::*;
#(
	parameter int Depth = 4
) (
	input wire CLK50MHZ,
	input wire rst,
	input wire rxReq,
	input wire [DataBits-1:0] rxData,
	input wire txAck,
	output logic rxAck,
	output logic txReq,
	output logic [DataBits-1:0] txData,
	output logic overflow
);

	localparam int AddrWidth = $clog2(Depth);
	localparam logic [AddrWidth:0] DepthCount = (AddrWidth + 1)'(Depth);

	logic [DataBits-1:0] mem [Depth];
	logic [AddrWidth-1:0] wrPtr;
	logic [AddrWidth-1:0] rdPtr;
	logic [AddrWidth:0] count;
	logic accept;
	logic full;
	logic push;
	logic pop;
	logic offer;

	// One accept per request
	// A full buffer drops the byte
	assign accept = rxReq && !rxAck;
	assign full = (count == DepthCount);
	assign push = accept && !full;
	assign pop = txReq && txAck;
	assign offer = !txReq && !txAck && (count != '0);

	always_ff @(posedge CLK50MHZ) begin
		if (push) begin
			mem[wrPtr] <= rxData;
		end
		if (offer) begin
			txData <= mem[rdPtr];
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (rst) begin
			rxAck <= 1'b0;
			txReq <= 1'b0;
			overflow <= 1'b0;
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			overflow <= accept && full;
			if (accept) begin
				rxAck <= 1'b1;
			end else if (!rxReq) begin
				rxAck <= 1'b0;
			end
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			// Entry leaves on the ack
			// Next offer waits for the ack to drop
			if (pop) begin
				txReq <= 1'b0;
				rdPtr <= rdPtr + 1'b1;
			end else if (offer) begin
				txReq <= 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge CLK50MHZ) disable iff (rst)
		$rose(txReq) |-> count != '0);

	// A full count must agree with wrapped pointers
	assert property (@(posedge CLK50MHZ) disable iff (rst)
		overflow |-> $past(count) == DepthCount && $past(wrPtr) == $past(rdPtr));

endmodule

`default_nettype wire

/* tbUartTasks.svh */
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH
`default_nettype none

// Drive point just after a rising edge
task automatic alignDrive();
	@(posedge CLK50MHZ);
	#(DriveDelayNs);
endtask

task automatic waitBits(input int bits);
	repeat (bits * BitCycles) @(posedge CLK50MHZ);
	#(DriveDelayNs);
endtask

// Start bit, data LSB first, given stop level, then idle line
task automatic sendFrame(input logic [DataBits-1:0] data, input logic stopBit);
	logic [DataBits+1:0] frame;
	frame = {stopBit, data, 1'b0};
	for (int i = 0; i < DataBits + 2; i++) begin
		rxd = frame[i];
		repeat (BitCycles) @(posedge CLK50MHZ);
		#(DriveDelayNs);
	end
	rxd = 1'b1;
endtask

// Edge is seen half a clock late, so samples land between clock edges
task automatic captureFrame(input int timeoutBits, output logic [DataBits-1:0] data,
		output logic seen);
	int waited;
	waited = 0;
	data = '0;
	@(negedge CLK50MHZ);
	while (txd !== 1'b0 && waited < timeoutBits * BitCycles) begin
		@(negedge CLK50MHZ);
		waited++;
	end
	seen = (txd === 1'b0);
	if (seen) begin
		#(BitNs / 2);
		checkValue("txd start bit", 32'(txd), 32'h0);
		for (int i = 0; i < DataBits; i++) begin
			#(BitNs);
			data[i] = txd;
		end
		#(BitNs);
		checkValue("txd stop bit", 32'(txd), 32'h1);
	end
endtask

task automatic testResetState();
	int errorsBefore;
	errorsBefore = errorCount;
	waitBits(20);
	checkValue("txd falling edges", txdFallCount, 0);
	checkValue("txd", 32'(txd), 32'h1);
	checkValue("framingError pulses", framingErrorCount, 0);
	checkValue("overflow pulses", overflowCount, 0);
	finishTest("reset state", errorsBefore);
endtask

task automatic testSingleEcho();
	int errorsBefore;
	logic [DataBits-1:0] sent;
	logic [DataBits-1:0] got;
	logic seen;
	errorsBefore = errorCount;
	randomByte(sent);
	alignDrive();
	fork
		sendFrame(sent, 1'b1);
		captureFrame(CaptureTimeoutBits, got, seen);
	join
	if (seen) begin
		checkValue("txd data", 32'(got), 32'(sent));
	end else begin
		reportFailure("the echo frame never appeared on txd");
	end
	finishTest("single echo", errorsBefore);
endtask

task automatic testStream();
	int errorsBefore;
	int overflowBefore;
	logic [DataBits-1:0] sent [StreamLength];
	logic [DataBits-1:0] got;
	logic seen;
	errorsBefore = errorCount;
	overflowBefore = overflowCount;
	for (int i = 0; i < StreamLength; i++) begin
		randomByte(sent[i]);
	end
	alignDrive();
	fork
		begin
			for (int i = 0; i < StreamLength; i++) begin
				sendFrame(sent[i], 1'b1);
			end
		end
		begin
			for (int i = 0; i < StreamLength; i++) begin
				captureFrame(CaptureTimeoutBits, got, seen);
				if (seen) begin
					checkValue("txd data", 32'(got), 32'(sent[i]));
				end else begin
					reportFailure("a frame of the stream is missing on txd");
				end
			end
		end
	join
	checkValue("overflow pulses", overflowCount - overflowBefore, 0);
	finishTest("back-to-back stream", errorsBefore);
endtask

task automatic testFramingError();
	int errorsBefore;
	int framingBefore;
	int fallBefore;
	logic [DataBits-1:0] sent;
	errorsBefore = errorCount;
	framingBefore = framingErrorCount;
	fallBefore = txdFallCount;
	randomByte(sent);
	alignDrive();
	sendFrame(sent, 1'b0);
	waitBits(15);
	checkValue("framingError pulses", framingErrorCount - framingBefore, 1);
	checkValue("txd falling edges", txdFallCount - fallBefore, 0);
	finishTest("framing error", errorsBefore);
endtask

// Bytes beyond the FIFO depth are dropped while the output is held off
task automatic testStall();
	int errorsBefore;
	int overflowBefore;
	int fallBefore;
	logic [DataBits-1:0] value;
	errorsBefore = errorCount;
	overflowBefore = overflowCount;
	fallBefore = txdFallCount;
	stalledBytes.delete();
	alignDrive();
	txEnable = 1'b0;
	for (int i = 0; i < Depth + 2; i++) begin
		randomByte(value);
		stalledBytes.push_back(value);
		sendFrame(value, 1'b1);
	end
	waitBits(2);
	checkValue("txd falling edges", txdFallCount - fallBefore, 0);
	checkValue("overflow pulses", overflowCount - overflowBefore, 2);
	finishTest("flow control and overflow", errorsBefore);
endtask

task automatic testResume();
	int errorsBefore;
	int fallBefore;
	logic [DataBits-1:0] got;
	logic seen;
	errorsBefore = errorCount;
	alignDrive();
	txEnable = 1'b1;
	for (int i = 0; i < Depth; i++) begin
		captureFrame(CaptureTimeoutBits, got, seen);
		if (seen) begin
			checkValue("txd data", 32'(got), 32'(stalledBytes[i]));
		end else begin
			reportFailure("a stored byte was not sent after txEnable rose");
		end
	end
	fallBefore = txdFallCount;
	waitBits(15);
	checkValue("txd falling edges", txdFallCount - fallBefore, 0);
	checkValue("txd", 32'(txd), 32'h1);
	finishTest("resume after stall", errorsBefore);
endtask

`default_nettype wire
`endif

/* tbUartLink.sv */
`timescale 1ns/1ns
`default_nettype none

module tbUartLink
	import uartPkg::*;
();

	localparam int ClkFrequency = 50000000;
	localparam int Baud = 1562500;
	localparam int Oversampling = 8;
	localparam int Depth = 4;
	localparam int ClkPeriodNs = 20;
	localparam int DriveDelayNs = 2;
	localparam int BitCycles = ClkFrequency / Baud;
	localparam int BitNs = BitCycles * ClkPeriodNs;
	localparam int StreamLength = 8;
	localparam int CaptureTimeoutBits = 20;
	// Frames of all tests, the margin covers the idle checks
	localparam int TotalFrames = 1 + StreamLength + 1 + (Depth + 2) + Depth;
	localparam int WatchdogNs = 2 * TotalFrames * 10 * BitNs + 100 * BitNs;

	logic CLK50MHZ;
	logic rst;
	logic rxd;
	logic txEnable;
	wire txd;
	wire framingError;
	wire overflow;

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int framingErrorCount = 0;
	int overflowCount = 0;
	int txdFallCount = 0;
	logic txdPrev = 1'b1;
	logic [15:0] lfsrState = 16'd19026;
	logic [DataBits-1:0] stalledBytes [$];

	uartLink #(
		.ClkFrequency(ClkFrequency),
		.Baud(Baud),
		.Oversampling(Oversampling),
		.Depth(Depth)
	) u_dut (
		.CLK50MHZ(CLK50MHZ),
		.rst(rst),
		.rxd(rxd),
		.txEnable(txEnable),
		.txd(txd),
		.framingError(framingError),
		.overflow(overflow)
	);

	initial begin
		CLK50MHZ = 1'b0;
		forever #(ClkPeriodNs / 2) CLK50MHZ = ~CLK50MHZ;
	end

	// Pulse and frame counters, sampled away from the active edge
	always @(negedge CLK50MHZ) begin
		if (!rst) begin
			if (framingError === 1'b1) framingErrorCount++;
			if (overflow === 1'b1) overflowCount++;
			if (txdPrev === 1'b1 && txd === 1'b0) txdFallCount++;
		end
		txdPrev = txd;
	end

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic randomByte(output logic [DataBits-1:0] value);
		for (int i = 0; i < DataBits; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value[i] = lfsrState[0];
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t ns", name, actual,
				expected, $time);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		$display("Test %0d, %s, done with %0d errors", testCount, name,
			errorCount - errorsBefore);
	endtask

	initial begin
		#(WatchdogNs);
		$display("Watchdog expired after %0d ns before the tests completed", WatchdogNs);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		rst = 1'b1;
		rxd = 1'b1;
		txEnable = 1'b1;
		repeat (4) @(posedge CLK50MHZ);
		#(DriveDelayNs);
		rst = 1'b0;
		testResetState();
		testSingleEcho();
		testStream();
		testFramingError();
		testStall();
		testResume();
		$display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
			errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	`include "tbUartTasks.svh"

endmodule

`default_nettype wire

/* uartLink.sv */
`timescale 1ns/1ns
`default_nettype none

module uartLink
	import uartPkg::*;
#(
	parameter int ClkFrequency = 50000000,
	parameter int Baud = 115200,
	parameter int Oversampling = 8,
	parameter int Depth = 4
) (
	input wire CLK50MHZ,
	input wire rst,
	input wire rxd,
	input wire txEnable,
	output wire txd,
	output wire framingError,
	output wire overflow
);

	// Receiver to FIFO
	wire rxReq;
	wire rxAck;
	wire [DataBits-1:0] rxData;

	// FIFO to transmitter
	wire txReq;
	wire txAck;
	wire [DataBits-1:0] txData;

	uartReceiver #(
		.ClkFrequency(ClkFrequency),
		.Baud(Baud),
		.Oversampling(Oversampling)
	) u_receiver (
		.CLK50MHZ(CLK50MHZ),
		.rst(rst),
		.rxd(rxd),
		.rxAck(rxAck),
		.rxReq(rxReq),
		.rxData(rxData),
		.framingError(framingError)
	);

	byteFifo #(
		.Depth(Depth)
	) u_fifo (
		.CLK50MHZ(CLK50MHZ),
		.rst(rst),
		.rxReq(rxReq),
		.rxData(rxData),
		.txAck(txAck),
		.rxAck(rxAck),
		.txReq(txReq),
		.txData(txData),
		.overflow(overflow)
	);

	uartTransmitter #(
		.ClkFrequency(ClkFrequency),
		.Baud(Baud)
	) u_transmitter (
		.CLK50MHZ(CLK50MHZ),
		.rst(rst),
		.txReq(txReq),
		.txData(txData),
		.txEnable(txEnable),
		.txAck(txAck),
		.txd(txd)
	);

endmodule

`default_nettype wire

/* uartPkg.sv */
`default_nettype none

package uartPkg;

	// Frame layout, 8N1
	localparam int DataBits = 8;

	// Fractional bits of the baud phase accumulator
	localparam int BaudAccWidth = 17;

	// Transmitter FSM
	typedef enum logic [1:0] {
		TxIdle  = 2'd0,
		TxStart = 2'd1,
		TxData  = 2'd2,
		TxStop  = 2'd3
	} txState_t;

	// Receiver FSM
	typedef enum logic [1:0] {
		RxIdle  = 2'd0,
		RxStart = 2'd1,
		RxData  = 2'd2,
		RxStop  = 2'd3
	} rxState_t;

endpackage

`default_nettype wire

/* uartReceiver.sv */
`timescale 1ns/1ns
`default_nettype none

module uartReceiver
	import uartPkg::*;
#(
	parameter int ClkFrequency = 50000000,
	parameter int Baud = 115200,
	parameter int Oversampling = 8
) (
	input wire CLK50MHZ,
	input wire rst,
	input wire rxd,
	input wire rxAck,
	output logic rxReq,
	output logic [DataBits-1:0] rxData,
	output logic framingError
);

	localparam int CntWidth = $clog2(Oversampling);
	localparam int IdxWidth = $clog2(DataBits);
	localparam logic [CntWidth-1:0] HalfCnt = CntWidth'(Oversampling / 2 - 1);
	localparam logic [CntWidth-1:0] FullCnt = CntWidth'(Oversampling - 1);

	rxState_t state;
	logic rxMeta;
	logic rxSync;
	logic rxPrev;
	logic fallEdge;
	logic sampleEnable;
	logic sampleTick;
	logic bitEnd;
	logic [CntWidth-1:0] tickCnt;
	logic [IdxWidth-1:0] bitIdx;
	logic [DataBits-1:0] shiftReg;

	// Two-flop synchronizer plus one stage for edge detection
	always_ff @(posedge CLK50MHZ) begin
		if (rst) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end else begin
			rxMeta <= rxd;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	assign fallEdge = (state == RxIdle) && rxPrev && !rxSync;

	// Starting on the edge itself saves a cycle of sampling lag
	assign sampleEnable = (state != RxIdle) || fallEdge;

	baudTickGen #(
		.ClkFrequency(ClkFrequency),
		.Rate(Baud * Oversampling)
	) u_sampleGen (
		.CLK50MHZ(CLK50MHZ),
		.rst(rst),
		.enable(sampleEnable),
		.tick(sampleTick)
	);

	// Middle of a data or stop bit
	assign bitEnd = sampleTick && (tickCnt == FullCnt);

	always_ff @(posedge CLK50MHZ) begin
		if (rst) begin
			state <= RxIdle;
			tickCnt <= '0;
			bitIdx <= '0;
			rxReq <= 1'b0;
			framingError <= 1'b0;
		end else begin
			framingError <= 1'b0;
			// Close the handshake once the FIFO has answered
			if (rxReq && rxAck) begin
				rxReq <= 1'b0;
			end
			case (state)
				RxIdle: begin
					tickCnt <= '0;
					if (fallEdge) begin
						state <= RxStart;
					end
				end
				RxStart: begin
					if (sampleTick) begin
						if (tickCnt == HalfCnt) begin
							tickCnt <= '0;
							bitIdx <= '0;
							// A glitch shorter than half a bit is ignored
							state <= rxSync ? RxIdle : RxData;
						end else begin
							tickCnt <= tickCnt + 1'b1;
						end
					end
				end
				RxData: begin
					if (sampleTick) begin
						tickCnt <= tickCnt + 1'b1;
					end
					if (bitEnd) begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == IdxWidth'(DataBits - 1)) begin
							state <= RxStop;
						end
					end
				end
				RxStop: begin
					if (sampleTick) begin
						tickCnt <= tickCnt + 1'b1;
					end
					if (bitEnd) begin
						state <= RxIdle;
						if (rxSync) begin
							rxReq <= 1'b1;
						end else begin
							framingError <= 1'b1;
						end
					end
				end
				default: state <= RxIdle;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge CLK50MHZ) begin
		if (state == RxData && bitEnd) begin
			shiftReg <= {rxSync, shiftReg[DataBits-1:1]};
		end
		if (state == RxStop && bitEnd && rxSync) begin
			rxData <= shiftReg;
		end
	end

	// The FIFO may take the byte at any point while the request is open
	assert property (@(posedge CLK50MHZ) disable iff (rst)
		rxReq && !rxAck |=> $stable(rxData));

endmodule

`default_nettype wire

/* uartTransmitter.sv */
`timescale 1ns/1ns
`default_nettype none

module uartTransmitter
	import uartPkg::*;
#(
	parameter int ClkFrequency = 50000000,
	parameter int Baud = 115200
) (
	input wire CLK50MHZ,
	input wire rst,
	input wire txReq,
	input wire [DataBits-1:0] txData,
	input wire txEnable,
	output logic txAck,
	output logic txd
);

	localparam int IdxWidth = $clog2(DataBits);

	txState_t state;
	logic baudEnable;
	logic baudTick;
	logic take;
	logic [IdxWidth-1:0] bitIdx;
	logic [DataBits-1:0] shiftReg;

	// New byte only from idle, with the host allowing output
	assign take = (state == TxIdle) && txReq && txEnable && !txAck;
	assign baudEnable = (state != TxIdle);

	baudTickGen #(
		.ClkFrequency(ClkFrequency),
		.Rate(Baud)
	) u_baudGen (
		.CLK50MHZ(CLK50MHZ),
		.rst(rst),
		.enable(baudEnable),
		.tick(baudTick)
	);

	// Line is registered so state changes reach txd glitch free
	always_ff @(posedge CLK50MHZ) begin
		if (rst) begin
			state <= TxIdle;
			bitIdx <= '0;
			txAck <= 1'b0;
			txd <= 1'b1;
		end else begin
			if (take) begin
				txAck <= 1'b1;
			end else if (!txReq) begin
				txAck <= 1'b0;
			end
			case (state)
				TxIdle: begin
					txd <= 1'b1;
					if (take) begin
						txd <= 1'b0;
						state <= TxStart;
					end
				end
				TxStart: begin
					if (baudTick) begin
						txd <= shiftReg[0];
						bitIdx <= '0;
						state <= TxData;
					end
				end
				TxData: begin
					if (baudTick) begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == IdxWidth'(DataBits - 1)) begin
							txd <= 1'b1;
							state <= TxStop;
						end else begin
							txd <= shiftReg[0];
						end
					end
				end
				// Full stop period before the next byte is taken
				TxStop: begin
					if (baudTick) begin
						state <= TxIdle;
					end
				end
				default: state <= TxIdle;
			endcase
		end
	end

	// Bit 0 goes out at the end of the start bit, then shift right
	always_ff @(posedge CLK50MHZ) begin
		if (take) begin
			shiftReg <= txData;
		end else if (baudTick && (state == TxStart || state == TxData)) begin
			shiftReg <= {1'b0, shiftReg[DataBits-1:1]};
		end
	end

	assert property (@(posedge CLK50MHZ) disable iff (rst)
		state == TxIdle |-> txd);

endmodule

`default_nettype wire
